//--- src/cpuCtrlPkg.sv
`default_nettype none

package cpuCtrlPkg;

	localparam int OpcodeWidth     = 6;
	localparam int FunctWidth      = 6;
	localparam int InstrFieldWidth = 26;

	// Opcodes handled by this controller
	localparam logic [OpcodeWidth-1:0] OpRType = 6'h00;
	localparam logic [OpcodeWidth-1:0] OpJ     = 6'h02;
	localparam logic [OpcodeWidth-1:0] OpJal   = 6'h03;
	localparam logic [OpcodeWidth-1:0] OpBeq   = 6'h04;
	localparam logic [OpcodeWidth-1:0] OpBne   = 6'h05;
	localparam logic [OpcodeWidth-1:0] OpAddi  = 6'h08;
	localparam logic [OpcodeWidth-1:0] OpAddiu = 6'h09;
	localparam logic [OpcodeWidth-1:0] OpLw    = 6'h23;
	localparam logic [OpcodeWidth-1:0] OpSw    = 6'h2b;

	localparam logic [FunctWidth-1:0] FunctAdd   = 6'h20;
	localparam logic [FunctWidth-1:0] FunctSub   = 6'h22;
	localparam logic [FunctWidth-1:0] FunctAnd   = 6'h24;
	localparam logic [FunctWidth-1:0] FunctJr    = 6'h08;
	localparam logic [FunctWidth-1:0] FunctBreak = 6'h0d;
	localparam logic [FunctWidth-1:0] FunctNop   = 6'h00;

	typedef enum logic [5:0] {
		Reset, Inicio, Fetch, FetchWait, Decode,
		ArithExec, ArithCheck, ArithWrite,
		ImmExec, ImmCheck, ImmWrite,
		BranchTarget, BranchCompare,
		LoadAddr, LoadRead, LoadWait, LoadCapture, LoadWrite,
		StoreAddr, StoreSetup, StoreWrite,
		Jump, JumpLink, JumpReg, Break,
		ExcSave, ExcVector, ExcLoad
	} ctrlState_t;

	typedef enum logic [3:0] {
		ClsNop, ClsArith, ClsArithImm, ClsBeq, ClsBne, ClsLoad,
		ClsStore, ClsJump, ClsJal, ClsJr, ClsBreak, ClsIllegal
	} opClass_t;

	// ALU function codes as seen by the datapath ALU
	typedef enum logic [2:0] {
		AluPass = 3'b000,
		AluAdd  = 3'b001,
		AluSub  = 3'b010,
		AluAnd  = 3'b011,
		AluNone = 3'b111
	} aluOp_t;

	typedef enum logic [1:0] {ASelPc = 2'd0, ASelRegA = 2'd1} aSel_t;

	typedef enum logic [1:0] {
		BSelRegB = 2'd0, BSelFour = 2'd1, BSelImm = 2'd2, BSelImmShifted = 2'd3
	} bSel_t;

	typedef enum logic [2:0] {
		PcAluResult = 3'd0, PcAluOut = 3'd1, PcJumpTarget = 3'd2,
		PcRegA = 3'd3, PcExcData = 3'd5
	} pcSrc_t;

	typedef enum logic [2:0] {
		AddrPc = 3'd0, AddrAluOut = 3'd1, AddrBadOpVector = 3'd2, AddrOverflowVector = 3'd3
	} memAddrSel_t;

	typedef enum logic [1:0] {DestRt = 2'd0, DestRd = 2'd1, DestRa = 2'd2, DestSp = 2'd3} destSel_t;

	typedef enum logic [3:0] {
		WbAluOut = 4'd0, WbMemData = 4'd1, WbReturnPc = 4'd5, WbStackInit = 4'd11
	} wbSel_t;

	typedef enum logic {ExcOverflow, ExcBadOpcode} excCause_t;

endpackage

`default_nettype wire

//--- src/decodeIf.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded instruction info, constant for the whole instruction
interface decodeIf;
	import cpuCtrlPkg::*;

	opClass_t  opClass;
	aluOp_t    aluOp;
	excCause_t excCause;
	logic      trapOnOverflow;

	modport dec (output opClass, aluOp, excCause, trapOnOverflow);
	modport seq (input opClass, trapOnOverflow);
	modport enc (input opClass, aluOp, excCause);

endinterface

`default_nettype wire

//--- src/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input  logic [cpuCtrlPkg::OpcodeWidth-1:0]     opcode,
	input  logic [cpuCtrlPkg::FunctWidth-1:0]      funct,
	input  logic [cpuCtrlPkg::InstrFieldWidth-1:0] instrField,
	decodeIf.dec                                   dec
);
	import cpuCtrlPkg::*;

	always_comb begin
		dec.opClass = ClsIllegal;
		dec.aluOp = AluNone;
		dec.trapOnOverflow = 1'b0;
		case (opcode)
			OpRType: begin
				case (funct)
					FunctAdd: begin
						dec.opClass = ClsArith;
						dec.aluOp = AluAdd;
						dec.trapOnOverflow = 1'b1;
					end
					FunctSub: begin
						dec.opClass = ClsArith;
						dec.aluOp = AluSub;
						dec.trapOnOverflow = 1'b1;
					end
					FunctAnd: begin
						dec.opClass = ClsArith;
						dec.aluOp = AluAnd;
						dec.trapOnOverflow = 1'b1;
					end
					FunctJr: dec.opClass = ClsJr;
					FunctBreak: dec.opClass = ClsBreak;
					FunctNop: begin
						if (instrField == '0) // Only the all-zero word is a NOP
							dec.opClass = ClsNop;
					end
					default: dec.opClass = ClsIllegal;
				endcase
			end
			OpAddi: begin
				dec.opClass = ClsArithImm;
				dec.aluOp = AluAdd;
				dec.trapOnOverflow = 1'b1;
			end
			OpAddiu: begin
				dec.opClass = ClsArithImm;
				dec.aluOp = AluAdd; // Never traps
			end
			OpBeq: dec.opClass = ClsBeq;
			OpBne: dec.opClass = ClsBne;
			OpLw: dec.opClass = ClsLoad;
			OpSw: dec.opClass = ClsStore;
			OpJ: dec.opClass = ClsJump;
			OpJal: dec.opClass = ClsJal;
			default: dec.opClass = ClsIllegal;
		endcase
	end

	always_comb begin
		if (opcode == OpRType || opcode == OpAddi)
			dec.excCause = ExcOverflow;
		else
			dec.excCause = ExcBadOpcode;
	end

endmodule

`default_nettype wire

//--- src/stateSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stateSequencer (
	input  logic                   Clk,
	input  logic                   Reset,
	input  logic                   overflow,
	decodeIf.seq                   seq,
	output cpuCtrlPkg::ctrlState_t state
);
	import cpuCtrlPkg::*;

	ctrlState_t nextState;

	always_ff @(posedge Clk, posedge Reset) begin
		if (Reset)
			state <= cpuCtrlPkg::Reset; // Port name hides the enum literal
		else
			state <= nextState;
	end

	always_comb begin
		nextState = Inicio; // End of every sequence
		case (state)
			Inicio: nextState = Fetch;
			Fetch: nextState = FetchWait;
			FetchWait: nextState = Decode;
			Decode: begin
				case (seq.opClass)
					ClsNop: nextState = Inicio;
					ClsArith: nextState = ArithExec;
					ClsArithImm: nextState = ImmExec;
					ClsBeq, ClsBne: nextState = BranchTarget;
					ClsLoad: nextState = LoadAddr;
					ClsStore: nextState = StoreAddr;
					ClsJump: nextState = Jump;
					ClsJal: nextState = JumpLink;
					ClsJr: nextState = JumpReg;
					ClsBreak: nextState = Break;
					default: nextState = ExcSave;
				endcase
			end
			ArithExec: nextState = ArithCheck;
			ArithCheck: nextState = (overflow && seq.trapOnOverflow) ? ExcSave : ArithWrite;
			ImmExec: nextState = ImmCheck;
			ImmCheck: nextState = (overflow && seq.trapOnOverflow) ? ExcSave : ImmWrite;
			BranchTarget: nextState = BranchCompare;
			LoadAddr: nextState = LoadRead;
			LoadRead: nextState = LoadWait;
			LoadWait: nextState = LoadCapture;
			LoadCapture: nextState = LoadWrite;
			StoreAddr: nextState = StoreSetup;
			StoreSetup: nextState = StoreWrite;
			JumpLink: nextState = Jump; // Link first, then jump
			Break: nextState = Break;
			ExcSave: nextState = ExcVector;
			ExcVector: nextState = ExcLoad;
			default: nextState = Inicio;
		endcase
	end

endmodule

`default_nettype wire

//--- src/controlEncoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlEncoder (
	input  cpuCtrlPkg::ctrlState_t  state,
	decodeIf.enc                    enc,
	output cpuCtrlPkg::aSel_t       aSel,
	output cpuCtrlPkg::bSel_t       bSel,
	output cpuCtrlPkg::pcSrc_t      pcSrc,
	output cpuCtrlPkg::memAddrSel_t memAddrSel,
	output cpuCtrlPkg::destSel_t    destSel,
	output cpuCtrlPkg::wbSel_t      wbSel,
	output cpuCtrlPkg::aluOp_t      aluOp,
	output logic                    branchOnNotEqual,
	output logic                    memWrite,
	output logic                    loadAluOut,
	output logic                    loadA,
	output logic                    loadB,
	output logic                    loadMemData,
	output logic                    loadEpc,
	output logic                    irWrite,
	output logic                    pcWrite,
	output logic                    pcWriteCond,
	output logic                    regWrite
);
	import cpuCtrlPkg::*;

	memAddrSel_t excAddr;
	logic isBne;

	always_comb begin
		if (enc.excCause == ExcOverflow)
			excAddr = AddrOverflowVector;
		else
			excAddr = AddrBadOpVector;
	end

	assign isBne = (enc.opClass == ClsBne);

	always_comb begin
		aSel = ASelPc;
		bSel = BSelRegB;
		pcSrc = PcAluResult;
		memAddrSel = AddrPc;
		destSel = DestRt;
		wbSel = WbAluOut;
		aluOp = AluPass;
		branchOnNotEqual = 1'b0;
		memWrite = 1'b0;
		loadAluOut = 1'b0;
		loadA = 1'b0;
		loadB = 1'b0;
		loadMemData = 1'b0;
		loadEpc = 1'b0;
		irWrite = 1'b0;
		pcWrite = 1'b0;
		pcWriteCond = 1'b0;
		regWrite = 1'b0;
		case (state)
			Reset: begin
				regWrite = 1'b1; // Stack pointer init
				destSel = DestSp;
				wbSel = WbStackInit;
			end
			Fetch: begin
				bSel = BSelFour;
				aluOp = AluAdd;
			end
			FetchWait: irWrite = 1'b1;
			Decode: begin
				bSel = BSelFour;
				aluOp = AluAdd; // PC + 4
				irWrite = 1'b1;
				pcWrite = 1'b1;
				loadA = 1'b1;
				loadB = 1'b1;
			end
			ArithExec, ArithCheck, ArithWrite: begin
				aSel = ASelRegA;
				aluOp = enc.aluOp;
				loadAluOut = (state != ArithWrite);
				regWrite = (state == ArithWrite);
				destSel = DestRd;
			end
			ImmExec, ImmCheck, ImmWrite: begin
				aSel = ASelRegA;
				bSel = BSelImm;
				aluOp = enc.aluOp;
				loadAluOut = (state != ImmWrite);
				regWrite = (state == ImmWrite);
			end
			BranchTarget: begin
				bSel = BSelImmShifted;
				aluOp = AluAdd;
				loadAluOut = 1'b1; // Hold target for compare cycle
				branchOnNotEqual = isBne;
			end
			BranchCompare: begin
				aSel = ASelRegA;
				aluOp = AluSub;
				pcSrc = PcAluOut;
				pcWriteCond = 1'b1;
				branchOnNotEqual = isBne;
			end
			LoadAddr, StoreAddr: begin
				aSel = ASelRegA;
				bSel = BSelImm;
				aluOp = AluAdd;
				loadAluOut = 1'b1;
				memAddrSel = AddrAluOut;
			end
			LoadRead, LoadWait, StoreSetup: memAddrSel = AddrAluOut;
			LoadCapture: begin
				memAddrSel = AddrAluOut;
				loadMemData = 1'b1;
			end
			LoadWrite: begin
				memAddrSel = AddrAluOut;
				wbSel = WbMemData;
				regWrite = 1'b1;
			end
			StoreWrite: begin
				memAddrSel = AddrAluOut;
				memWrite = 1'b1;
			end
			Jump: begin
				pcSrc = PcJumpTarget;
				pcWrite = 1'b1;
			end
			JumpLink: begin
				destSel = DestRa;
				wbSel = WbReturnPc;
				regWrite = 1'b1;
			end
			JumpReg: begin
				pcSrc = PcRegA;
				pcWrite = 1'b1;
			end
			ExcSave: begin
				bSel = BSelFour;
				aluOp = AluSub; // EPC gets PC - 4
				memAddrSel = excAddr;
				loadEpc = 1'b1;
			end
			ExcVector, ExcLoad: begin
				memAddrSel = excAddr;
				pcSrc = PcExcData;
				pcWrite = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- src/cpuControl.sv
`timescale 1ns/1ps
`default_nettype none

module cpuControl (
	input  logic                                   Clk,
	input  logic                                   Reset,
	input  logic                                   overflow,
	input  logic [cpuCtrlPkg::OpcodeWidth-1:0]     opcode,
	input  logic [cpuCtrlPkg::FunctWidth-1:0]      funct,
	input  logic [cpuCtrlPkg::InstrFieldWidth-1:0] instrField,
	output cpuCtrlPkg::ctrlState_t                 state,
	output cpuCtrlPkg::aSel_t                      aSel,
	output cpuCtrlPkg::bSel_t                      bSel,
	output cpuCtrlPkg::pcSrc_t                     pcSrc,
	output cpuCtrlPkg::memAddrSel_t                memAddrSel,
	output cpuCtrlPkg::destSel_t                   destSel,
	output cpuCtrlPkg::wbSel_t                     wbSel,
	output cpuCtrlPkg::aluOp_t                     aluOp,
	output logic                                   branchOnNotEqual,
	output logic                                   memWrite,
	output logic                                   loadAluOut,
	output logic                                   loadA,
	output logic                                   loadB,
	output logic                                   loadMemData,
	output logic                                   loadEpc,
	output logic                                   irWrite,
	output logic                                   pcWrite,
	output logic                                   pcWriteCond,
	output logic                                   regWrite
);

	decodeIf decBus ();

	instrDecoder i_instrDecoder (
		.opcode     (opcode),
		.funct      (funct),
		.instrField (instrField),
		.dec        (decBus.dec)
	);

	stateSequencer i_stateSequencer (
		.Clk      (Clk),
		.Reset    (Reset),
		.overflow (overflow),
		.seq      (decBus.seq),
		.state    (state)
	);

	controlEncoder i_controlEncoder (
		.state            (state),
		.enc              (decBus.enc),
		.aSel             (aSel),
		.bSel             (bSel),
		.pcSrc            (pcSrc),
		.memAddrSel       (memAddrSel),
		.destSel          (destSel),
		.wbSel            (wbSel),
		.aluOp            (aluOp),
		.branchOnNotEqual (branchOnNotEqual),
		.memWrite         (memWrite),
		.loadAluOut       (loadAluOut),
		.loadA            (loadA),
		.loadB            (loadB),
		.loadMemData      (loadMemData),
		.loadEpc          (loadEpc),
		.irWrite          (irWrite),
		.pcWrite          (pcWrite),
		.pcWriteCond      (pcWriteCond),
		.regWrite         (regWrite)
	);

endmodule

`default_nettype wire

//--- sim/cpuControl_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cpuControlSva (
	input logic                   Clk,
	input logic                   Reset,
	input cpuCtrlPkg::ctrlState_t state,
	input logic                   memWrite,
	input logic                   irWrite
);
	import cpuCtrlPkg::*;

	int failCount = 0; // Polled by the testbench

	storeOnly: assert property (@(posedge Clk) disable iff (Reset)
		memWrite |-> state == StoreWrite)
		else begin
			failCount++;
			$error("memWrite high outside StoreWrite");
		end

	noFetchStoreClash: assert property (@(posedge Clk) !(irWrite && memWrite))
		else begin
			failCount++;
			$error("irWrite and memWrite high together");
		end

	resetState: assert property (@(posedge Clk) Reset |=> state == cpuCtrlPkg::Reset)
		else begin
			failCount++;
			$error("state not Reset one clock after Reset high");
		end

	breakHolds: assert property (@(posedge Clk) disable iff (Reset)
		state == Break |=> state == Break)
		else begin
			failCount++;
			$error("Break left without Reset");
		end

endmodule

bind cpuControl cpuControlSva i_cpuControlSva (.*);

`default_nettype wire

//--- sim/cpuControlTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuControlTb;
	import cpuCtrlPkg::*;

	logic Clk;
	logic Reset;
	logic overflow;
	logic [OpcodeWidth-1:0] opcode;
	logic [FunctWidth-1:0] funct;
	logic [InstrFieldWidth-1:0] instrField;
	ctrlState_t state;
	aSel_t aSel;
	bSel_t bSel;
	pcSrc_t pcSrc;
	memAddrSel_t memAddrSel;
	destSel_t destSel;
	wbSel_t wbSel;
	aluOp_t aluOp;
	logic branchOnNotEqual, memWrite, loadAluOut, loadA, loadB, loadMemData;
	logic loadEpc, irWrite, pcWrite, pcWriteCond, regWrite;
	logic [15:0] lfsr = 16'd19;

	cpuControl i_cpuControl (.*);

	initial begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] value);
		return {value[14:0], value[15] ^ value[13] ^ value[12] ^ value[10]};
	endfunction

	task automatic takeBits(input int count, output int bits);
		bits = 0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsrStep(lfsr);
			bits = (bits << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic abortRun();
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped after the first failure");
	endtask

	task automatic checkState(input string name, input ctrlState_t expected,
			input ctrlState_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: state expected %s, actual %s", name, expected.name(),
				actual.name());
			abortRun();
		end
	endtask

	task automatic checkAluOp(input string name, input aluOp_t expected, input aluOp_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: aluOp expected %s, actual %s", name, expected.name(),
				actual.name());
			abortRun();
		end
	endtask

	task automatic checkAddrSel(input string name, input memAddrSel_t expected,
			input memAddrSel_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: memAddrSel expected %s, actual %s", name, expected.name(),
				actual.name());
			abortRun();
		end
	endtask

	task automatic checkWbSel(input string name, input wbSel_t expected, input wbSel_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: wbSel expected %s, actual %s", name, expected.name(),
				actual.name());
			abortRun();
		end
	endtask

	task automatic checkDestSel(input string name, input destSel_t expected,
			input destSel_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: destSel expected %s, actual %s", name, expected.name(),
				actual.name());
			abortRun();
		end
	endtask

	task automatic checkASel(input string name, input aSel_t expected, input aSel_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: aSel expected %s, actual %s", name, expected.name(),
				actual.name());
			abortRun();
		end
	endtask

	task automatic checkBSel(input string name, input bSel_t expected, input bSel_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: bSel expected %s, actual %s", name, expected.name(),
				actual.name());
			abortRun();
		end
	endtask

	task automatic checkPcSrc(input string name, input pcSrc_t expected, input pcSrc_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: pcSrc expected %s, actual %s", name, expected.name(),
				actual.name());
			abortRun();
		end
	endtask

	task automatic checkBit(input string name, input string label, input logic expected,
			input logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: %s expected %b, actual %b", name, label, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkNoStrobes(input string name);
		checkBit(name, "any strobe", 1'b0, memWrite | loadAluOut | loadA | loadB | loadMemData |
			loadEpc | irWrite | pcWrite | pcWriteCond | regWrite);
	endtask

	task automatic nextCycle();
		@(negedge Clk);
	endtask

	task automatic waitInicio(input string name);
		int cycles;
		cycles = 0;
		while (state !== Inicio && cycles < 20) begin
			@(negedge Clk);
			cycles++;
		end
		if (state !== Inicio) begin
			$display("Timeout in %s: the FSM did not return to Inicio within 20 cycles", name);
			abortRun();
		end
	endtask

	task automatic checkResetState(input string name);
		checkState(name, cpuCtrlPkg::Reset, state);
		checkBit(name, "regWrite", 1'b1, regWrite);
		checkDestSel(name, DestSp, destSel);
		checkWbSel(name, WbStackInit, wbSel);
	endtask

	// Drives the instruction at Inicio, checks the prefix, ends in the first class state
	task automatic startInstr(input string name, input logic [OpcodeWidth-1:0] op,
			input logic [FunctWidth-1:0] fn, input logic [InstrFieldWidth-1:0] field,
			input logic ovf);
		waitInicio(name);
		opcode = op;
		funct = fn;
		instrField = field;
		overflow = ovf;
		checkNoStrobes(name);
		nextCycle();
		checkState(name, Fetch, state);
		checkNoStrobes(name);
		checkAluOp(name, AluAdd, aluOp);
		checkASel(name, ASelPc, aSel);
		checkBSel(name, BSelFour, bSel);
		nextCycle();
		checkState(name, FetchWait, state);
		checkBit(name, "irWrite", 1'b1, irWrite);
		nextCycle();
		checkState(name, Decode, state);
		checkBit(name, "irWrite", 1'b1, irWrite);
		checkBit(name, "pcWrite", 1'b1, pcWrite);
		checkBit(name, "loadA", 1'b1, loadA);
		checkBit(name, "loadB", 1'b1, loadB);
		checkAluOp(name, AluAdd, aluOp);
		checkBSel(name, BSelFour, bSel);
		checkPcSrc(name, PcAluResult, pcSrc);
		nextCycle();
	endtask

	task automatic checkExcSequence(input string name, input memAddrSel_t vector);
		checkState(name, ExcSave, state);
		checkBit(name, "loadEpc", 1'b1, loadEpc);
		checkAddrSel(name, vector, memAddrSel);
		checkAluOp(name, AluSub, aluOp);
		checkASel(name, ASelPc, aSel);
		checkBSel(name, BSelFour, bSel);
		nextCycle();
		checkState(name, ExcVector, state);
		checkBit(name, "loadEpc", 1'b0, loadEpc);
		checkBit(name, "pcWrite", 1'b1, pcWrite);
		checkPcSrc(name, PcExcData, pcSrc);
		checkAddrSel(name, vector, memAddrSel);
		nextCycle();
		checkState(name, ExcLoad, state);
		checkBit(name, "loadEpc", 1'b0, loadEpc);
		checkBit(name, "pcWrite", 1'b1, pcWrite);
		checkPcSrc(name, PcExcData, pcSrc);
		checkAddrSel(name, vector, memAddrSel);
		nextCycle();
		checkState(name, Inicio, state);
	endtask

	task automatic resetTest();
		repeat (8) begin
			@(negedge Clk);
			checkResetState("reset");
		end
		Reset = 1'b0;
		checkResetState("reset"); // Held until the next rising edge
		nextCycle();
		checkState("reset", Inicio, state);
		checkNoStrobes("reset");
	endtask

	task automatic arithTest();
		int pick;
		int ovf;
		logic [FunctWidth-1:0] fn;
		aluOp_t expOp;
		repeat (8) begin
			takeBits(2, pick);
			takeBits(1, ovf);
			case (pick)
				1: begin
					fn = FunctSub;
					expOp = AluSub;
				end
				2: begin
					fn = FunctAnd;
					expOp = AluAnd;
				end
				default: begin
					fn = FunctAdd;
					expOp = AluAdd;
				end
			endcase
			startInstr("arith", OpRType, fn, {20'h22345, fn}, ovf[0]);
			checkState("arith", ArithExec, state);
			checkAluOp("arith", expOp, aluOp);
			checkASel("arith", ASelRegA, aSel);
			checkBSel("arith", BSelRegB, bSel);
			checkBit("arith", "loadAluOut", 1'b1, loadAluOut);
			nextCycle();
			checkState("arith", ArithCheck, state);
			nextCycle();
			if (ovf[0]) begin
				checkExcSequence("arith", AddrOverflowVector);
			end else begin
				checkState("arith", ArithWrite, state);
				checkBit("arith", "regWrite", 1'b1, regWrite);
				checkDestSel("arith", DestRd, destSel);
				nextCycle();
				checkState("arith", Inicio, state);
			end
		end
	endtask

	task automatic immTest();
		startInstr("addi", OpAddi, 6'h00, 26'h0217fff, 1'b1);
		checkState("addi", ImmExec, state);
		checkAluOp("addi", AluAdd, aluOp);
		checkASel("addi", ASelRegA, aSel);
		checkBSel("addi", BSelImm, bSel);
		nextCycle();
		checkState("addi", ImmCheck, state);
		nextCycle();
		checkExcSequence("addi", AddrOverflowVector);
		startInstr("addiu", OpAddiu, 6'h00, 26'h0217fff, 1'b1);
		checkState("addiu", ImmExec, state);
		nextCycle();
		checkState("addiu", ImmCheck, state);
		nextCycle();
		checkState("addiu", ImmWrite, state);
		checkBit("addiu", "regWrite", 1'b1, regWrite);
		nextCycle();
		checkState("addiu", Inicio, state);
	endtask

	task automatic loadStoreTest();
		ctrlState_t loadSeq[5] = '{LoadAddr, LoadRead, LoadWait, LoadCapture, LoadWrite};
		ctrlState_t storeSeq[3] = '{StoreAddr, StoreSetup, StoreWrite};
		startInstr("lw", OpLw, 6'h00, 26'h0a20010, 1'b0);
		checkASel("lw", ASelRegA, aSel);
		checkBSel("lw", BSelImm, bSel);
		checkBit("lw", "loadAluOut", 1'b1, loadAluOut);
		foreach (loadSeq[i]) begin
			checkState("lw", loadSeq[i], state);
			checkBit("lw", "memWrite", 1'b0, memWrite);
			checkBit("lw", "loadMemData", loadSeq[i] == LoadCapture, loadMemData);
			checkBit("lw", "regWrite", loadSeq[i] == LoadWrite, regWrite);
			checkAddrSel("lw", AddrAluOut, memAddrSel);
			if (loadSeq[i] == LoadWrite)
				checkWbSel("lw", WbMemData, wbSel);
			nextCycle();
		end
		checkState("lw", Inicio, state);
		startInstr("sw", OpSw, 6'h00, 26'h0a20014, 1'b0);
		foreach (storeSeq[i]) begin
			checkState("sw", storeSeq[i], state);
			checkBit("sw", "memWrite", storeSeq[i] == StoreWrite, memWrite);
			checkAddrSel("sw", AddrAluOut, memAddrSel);
			nextCycle();
		end
		checkState("sw", Inicio, state);
	endtask

	task automatic branchTest(input string name, input logic [OpcodeWidth-1:0] op,
			input logic expBne);
		startInstr(name, op, 6'h00, 26'h0850003, 1'b0);
		checkState(name, BranchTarget, state);
		checkAluOp(name, AluAdd, aluOp);
		checkASel(name, ASelPc, aSel);
		checkBSel(name, BSelImmShifted, bSel);
		checkBit(name, "loadAluOut", 1'b1, loadAluOut);
		nextCycle();
		checkState(name, BranchCompare, state);
		checkBit(name, "pcWriteCond", 1'b1, pcWriteCond);
		checkBit(name, "branchOnNotEqual", expBne, branchOnNotEqual);
		checkAluOp(name, AluSub, aluOp);
		checkASel(name, ASelRegA, aSel);
		checkBSel(name, BSelRegB, bSel);
		checkPcSrc(name, PcAluOut, pcSrc);
		nextCycle();
		checkState(name, Inicio, state);
	endtask

	task automatic jumpTest();
		startInstr("j", OpJ, 6'h00, 26'h0000100, 1'b0);
		checkState("j", Jump, state);
		checkBit("j", "pcWrite", 1'b1, pcWrite);
		checkPcSrc("j", PcJumpTarget, pcSrc);
		nextCycle();
		checkState("j", Inicio, state);
		startInstr("jal", OpJal, 6'h00, 26'h0000200, 1'b0);
		checkState("jal", JumpLink, state);
		checkBit("jal", "regWrite", 1'b1, regWrite);
		checkDestSel("jal", DestRa, destSel);
		checkWbSel("jal", WbReturnPc, wbSel);
		nextCycle();
		checkState("jal", Jump, state);
		checkBit("jal", "pcWrite", 1'b1, pcWrite);
		checkPcSrc("jal", PcJumpTarget, pcSrc);
		nextCycle();
		checkState("jal", Inicio, state);
		startInstr("jr", OpRType, FunctJr, 26'h3e00008, 1'b0);
		checkState("jr", JumpReg, state);
		checkBit("jr", "pcWrite", 1'b1, pcWrite);
		checkPcSrc("jr", PcRegA, pcSrc);
		nextCycle();
		checkState("jr", Inicio, state);
	endtask

	task automatic breakTest();
		startInstr("illegal", 6'h3f, 6'h00, 26'h0000000, 1'b0);
		checkExcSequence("illegal", AddrBadOpVector);
		startInstr("break", OpRType, FunctBreak, 26'h000000d, 1'b0);
		repeat (10) begin
			checkState("break", Break, state);
			checkNoStrobes("break");
			nextCycle();
		end
		Reset = 1'b1; // Only way out of Break
		nextCycle();
		checkResetState("break");
		Reset = 1'b0;
		nextCycle();
		checkState("break", Inicio, state);
	endtask

	initial begin
		Reset = 1'b1;
		overflow = 1'b0;
		opcode = OpRType;
		funct = FunctNop;
		instrField = '0;
		resetTest();
		startInstr("nop", OpRType, FunctNop, 26'h0000000, 1'b0);
		checkState("nop", Inicio, state);
		arithTest();
		immTest();
		loadStoreTest();
		branchTest("beq", OpBeq, 1'b0);
		branchTest("bne", OpBne, 1'b1);
		jumpTest();
		breakTest();
		if (i_cpuControl.i_cpuControlSva.failCount != 0) begin
			$display("Assertion failures were reported during the run");
			abortRun();
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- cpuControl.f
src/cpuCtrlPkg.sv
src/decodeIf.sv
src/instrDecoder.sv
src/stateSequencer.sv
src/controlEncoder.sv
src/cpuControl.sv
sim/cpuControl_sva.sv
sim/cpuControlTb.sv

//--- Bender.yml
package:
  name: cpuControl

sources:
  - files:
      - src/cpuCtrlPkg.sv
      - src/decodeIf.sv
      - src/instrDecoder.sv
      - src/stateSequencer.sv
      - src/controlEncoder.sv
      - src/cpuControl.sv
  - target: simulation
    files:
      - sim/cpuControl_sva.sv
      - sim/cpuControlTb.sv
